// ==== src.f ====
+incdir+rtl
rtl/commit_pkg.sv
rtl/commit_alloc.sv
rtl/commit_slot.sv
rtl/commit_retire.sv
rtl/commit_window.sv
tests/commit_window_assert.sv
tests/commit_window_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the commit window testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module commit_window_tb

./obj_dir/Vcommit_window_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// ==== tests/commit_window_tb.sv ====
// Randomized testbench for the commit window.
// Stimulus comes from a 16 bit Fibonacci LFSR, so every run is the same.
// A model queue of dispatched PCs and a table of reported results give the
// expected retire order and values.

`timescale 1ns/10ps
`default_nettype none

`include "commit_cfg.svh"

module commit_window_tb;
    import commit_pkg::*;

    logic                     clk;
    logic                     rst;
    logic                     flush;
    logic [`COMMIT_LANES-1:0] disp_valid;
    lane_word_t               disp_pc;
    logic                     disp_ready;
    wb_arr_t                  wb;
    logic                     ret_ready;
    logic                     ret_valid;
    retire_t                  ret;

    logic [15:0] lfsr;
    word_t       next_pc;
    word_t       model_q[$];     // dispatched PCs, oldest first.
    word_t       pending[$];     // in flight and not yet reported.
    wb_t         results[word_t];
    retire_t     exp_ret;

    logic allow_dispatch;
    logic allow_flush;
    logic hold_ready;

    int value_errs;
    int order_errs;
    int timeouts;
    int retired;
    int flushes;

    commit_window u_dut (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .disp_valid (disp_valid),
        .disp_pc    (disp_pc),
        .disp_ready (disp_ready),
        .wb         (wb),
        .ret_ready  (ret_ready),
        .ret_valid  (ret_valid),
        .ret        (ret)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 16, 14, 13 and 11; one step per bit handed out.
    function automatic logic [63:0] lfsr_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic int pick(input int n);
        return int'(lfsr_bits(n));
    endfunction

    function automatic wb_t make_report(input word_t pc);
        wb_t r;
        r.valid = 1'b1;
        r.pc    = pc;
        r.rd    = reg_addr_t'(lfsr_bits(`COMMIT_REG_AW));
        r.wen   = 1'(lfsr_bits(1));
        r.data  = word_t'(lfsr_bits(`COMMIT_XLEN));
        return r;
    endfunction

    // the oldest dispatched PC must leave with exactly what was reported for it.
    function automatic retire_t expected_retire();
        retire_t e;
        word_t   pc;
        pc     = model_q[0];
        e.pc   = pc;
        e.rd   = results[pc].rd;
        e.wen  = results[pc].wen;
        e.data = results[pc].data;
        return e;
    endfunction

    always @(posedge clk) begin
        if (!rst && ret_valid === 1'b1 && ret_ready === 1'b1) begin
            if (model_q.size() == 0) begin
                order_errs++;
                $display("retire of pc %h while nothing is outstanding", ret.pc);
            end else if (!results.exists(model_q[0])) begin
                order_errs++;
                $display("pc %h retired before its result was reported", model_q[0]);
                void'(model_q.pop_front());
            end else begin
                exp_ret = expected_retire();
                if (ret.pc !== exp_ret.pc) begin
                    value_errs++;
                    $display("CHECK FAILED ret.pc: got %h, expected %h", ret.pc, exp_ret.pc);
                end
                if (ret.rd !== exp_ret.rd) begin
                    value_errs++;
                    $display("CHECK FAILED ret.rd: got %h, expected %h", ret.rd, exp_ret.rd);
                end
                if (ret.wen !== exp_ret.wen) begin
                    value_errs++;
                    $display("CHECK FAILED ret.wen: got %h, expected %h", ret.wen, exp_ret.wen);
                end
                if (ret.data !== exp_ret.data) begin
                    value_errs++;
                    $display("CHECK FAILED ret.data: got %h, expected %h",
                             ret.data, exp_ret.data);
                end
                void'(model_q.pop_front());
                retired++;
            end
        end
    end

    // one falling edge of stimulus; directed cycles report the newest PCs first.
    task automatic drive_cycle(input logic directed, input int lanes, input int n_reports);
        wb_arr_t                  wb_v;
        lane_word_t               pc_v;
        logic [`COMMIT_LANES-1:0] dv;
        int                       n_lanes;
        int                       idx;
        int                       p;
        int                       l;
        word_t                    rpc;
        logic                     exp_ready;
        logic                     exp_valid;
        @(negedge clk);
        exp_ready = (model_q.size() <= `COMMIT_SLOTS - `COMMIT_LANES);
        exp_valid = 1'b0;
        if (model_q.size() > 0) begin
            exp_valid = (results.exists(model_q[0]) != 0); // reported in an earlier cycle.
        end
        if (disp_ready !== exp_ready) begin
            value_errs++;
            $display("CHECK FAILED disp_ready: got %h, expected %h with %0d in flight",
                     disp_ready, exp_ready, model_q.size());
        end
        if (ret_valid !== exp_valid) begin
            value_errs++;
            $display("CHECK FAILED ret_valid: got %h, expected %h", ret_valid, exp_valid);
        end
        wb_v  = '0;
        pc_v  = '0;
        dv    = '0;
        flush = 1'b0;
        if (!directed && allow_flush && pick(5) == 0) begin
            flush = 1'b1;
            model_q.delete();
            pending.delete();
            flushes++;
        end else begin
            for (p = 0; p < `COMMIT_WB_PORTS; p++) begin
                idx = -1;
                if (pending.size() > 0) begin
                    if (directed && p < n_reports) begin
                        idx = pending.size() - 1;
                    end else if (!directed && pick(2) != 0) begin
                        idx = pick(8) % pending.size();
                    end
                end
                if (idx >= 0) begin
                    rpc = pending[idx];
                    pending.delete(idx);
                    wb_v[p] = make_report(rpc);
                    results[rpc] = wb_v[p];
                end
            end
            n_lanes = directed ? lanes : (allow_dispatch ? pick(2) % 3 : 0);
            if (n_lanes > 0 && disp_ready !== 1'b1) begin
                if (directed) begin
                    order_errs++;
                    $display("dispatch was refused although the window had room");
                end
                n_lanes = 0;
            end
            for (l = 0; l < n_lanes; l++) begin
                dv[l]   = 1'b1;
                pc_v[l] = next_pc;
                model_q.push_back(next_pc);
                pending.push_back(next_pc); // reportable from the next cycle on.
                next_pc = next_pc + word_t'(4);
            end
        end
        ret_ready  = directed ? 1'b1 : (hold_ready ? 1'b0 : (pick(2) != 0));
        disp_valid = dv;
        disp_pc    = pc_v;
        wb         = wb_v;
    endtask

    task automatic wait_drained(input int limit);
        int n;
        allow_dispatch = 1'b0;
        allow_flush    = 1'b0;
        hold_ready     = 1'b0;
        n = 0;
        while (model_q.size() != 0 && n < limit) begin
            drive_cycle(1'b0, 0, 0);
            n++;
        end
        if (model_q.size() != 0) begin
            timeouts++;
            $display("timeout: %0d instructions still in the window after %0d cycles",
                     model_q.size(), limit);
        end
    endtask

    initial begin
        int n;
        int base;
        int held;
        rst            = 1'b1;
        flush          = 1'b0;
        disp_valid     = '0;
        disp_pc        = '0;
        wb             = '0;
        ret_ready      = 1'b0;
        lfsr           = 16'd49;
        next_pc        = 64'h0000_0000_8000_0000;
        allow_dispatch = 1'b0;
        allow_flush    = 1'b0;
        hold_ready     = 1'b0;
        value_errs     = 0;
        order_errs     = 0;
        timeouts       = 0;
        retired        = 0;
        flushes        = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (ret_valid !== 1'b0) begin
            value_errs++;
            $display("CHECK FAILED ret_valid: got %h, expected 0 after reset", ret_valid);
        end
        if (disp_ready !== 1'b1) begin
            value_errs++;
            $display("CHECK FAILED disp_ready: got %h, expected 1 after reset", disp_ready);
        end

        // three pairs complete newest first, the last three on all ports at once.
        repeat (3) drive_cycle(1'b1, 2, 0);
        repeat (3) drive_cycle(1'b1, 0, 1);
        drive_cycle(1'b1, 0, 3);
        wait_drained(100);

        if (timeouts == 0) begin
            allow_dispatch = 1'b1;
            hold_ready     = 1'b1;
            n = 0;
            while (disp_ready === 1'b1 && n < 100) begin
                drive_cycle(1'b0, 0, 0);
                n++;
            end
            if (disp_ready === 1'b1) begin
                timeouts++;
                $display("timeout: disp_ready never fell while retire was stalled");
            end
            repeat (6) drive_cycle(1'b0, 0, 0);
            base = retired;
            held = model_q.size();
            wait_drained(400);
            if (timeouts == 0 && retired != base + held) begin
                order_errs++;
                $display("%0d instructions retired after the stall, %0d were held",
                         retired - base, held);
            end
        end

        if (timeouts == 0) begin
            allow_dispatch = 1'b1;
            allow_flush    = 1'b1;
            hold_ready     = 1'b0;
            repeat (600) drive_cycle(1'b0, 0, 0);
            wait_drained(400);
        end

        $display("errors: %0d value, %0d ordering, %0d timeout; %0d retired, %0d flushes",
                 value_errs, order_errs, timeouts, retired, flushes);
        if (value_errs == 0 && order_errs == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/commit_window_assert.sv ====
// Protocol checks on the commit window ports.
// The occupancy here is rebuilt from the dispatch and retire handshakes only.

`timescale 1ns/10ps
`default_nettype none

`include "commit_cfg.svh"

module commit_window_assert (
    input logic                     clk,
    input logic                     rst,
    input logic                     flush,
    input logic [`COMMIT_LANES-1:0] disp_valid,
    input logic                     disp_ready,
    input logic                     ret_valid,
    input logic                     ret_ready,
    input commit_pkg::retire_t      ret
);
    import commit_pkg::*;

    count_t occupancy;
    count_t accepted;

    always_comb begin
        accepted = '0;
        for (int l = 0; l < `COMMIT_LANES; l++) begin
            if (disp_ready && disp_valid[l]) begin
                accepted = accepted + count_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + accepted - count_t'(ret_valid && ret_ready);
        end
    end

    a_quiet_after_clear: assert property (@(posedge clk) (rst || flush) |=> !ret_valid)
        else $error("ret_valid high in the cycle after reset or flush");

    a_ret_stable: assert property (@(posedge clk) disable iff (rst)
        (ret_valid && !ret_ready) |=> $stable(ret))
        else $error("ret changed while waiting for ret_ready");

    a_room_for_pair: assert property (@(posedge clk) disable iff (rst)
        disp_ready |-> (occupancy <= count_t'(`COMMIT_SLOTS - `COMMIT_LANES)))
        else $error("disp_ready high with fewer than two free slots");

endmodule

bind commit_window commit_window_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .disp_valid (disp_valid),
    .disp_ready (disp_ready),
    .ret_valid  (ret_valid),
    .ret_ready  (ret_ready),
    .ret        (ret)
);

`default_nettype wire

// ==== rtl/commit_window.sv ====
// Commit window for a dual-issue in-order core.
// Dispatch and retire use valid/ready; writeback has no ready and a report
// must come at least one cycle after its PC was dispatched.
// Results leave in program order, one register write per cycle.

`timescale 1ns/10ps
`default_nettype none

`include "commit_cfg.svh"

module commit_window (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic [`COMMIT_LANES-1:0]   disp_valid,
    input  commit_pkg::lane_word_t     disp_pc,
    output logic                       disp_ready,
    input  commit_pkg::wb_arr_t        wb,
    input  logic                       ret_ready,
    output logic                       ret_valid,
    output commit_pkg::retire_t        ret
);
    import commit_pkg::*;

    logic [`COMMIT_SLOTS-1:0] alloc;
    slot_word_t               alloc_pc;
    logic [`COMMIT_SLOTS-1:0] rel;
    entry_arr_t               entries;
    logic                     retire_fire;

    commit_alloc u_alloc (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .disp_valid  (disp_valid),
        .disp_pc     (disp_pc),
        .retire_fire (retire_fire),
        .disp_ready  (disp_ready),
        .alloc       (alloc),
        .alloc_pc    (alloc_pc)
    );

    // every slot sees all writeback ports.
    for (genvar s = 0; s < `COMMIT_SLOTS; s++) begin : g_slot
        commit_slot u_slot (
            .clk      (clk),
            .rst      (rst),
            .flush    (flush),
            .alloc    (alloc[s]),
            .alloc_pc (alloc_pc[s]),
            .wb       (wb),
            .rel      (rel[s]),
            .entry    (entries[s])
        );
    end

    commit_retire u_retire (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .entries     (entries),
        .ret_ready   (ret_ready),
        .ret_valid   (ret_valid),
        .ret         (ret),
        .rel         (rel),
        .retire_fire (retire_fire)
    );

endmodule

`default_nettype wire

// ==== rtl/commit_retire.sv ====
// Retire side of the window: head pointer and the register write handshake.
// ret holds still while ret_ready is low, as the head slot only changes
// at its own release. No handshake is offered in a flush cycle.

`timescale 1ns/10ps
`default_nettype none

`include "commit_cfg.svh"

module commit_retire (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  commit_pkg::entry_arr_t     entries,
    input  logic                       ret_ready,
    output logic                       ret_valid,
    output commit_pkg::retire_t        ret,
    output logic [`COMMIT_SLOTS-1:0]   rel,
    output logic                       retire_fire
);
    import commit_pkg::*;

    slot_idx_t head;
    entry_t    head_entry;

    assign head_entry = entries[head];

    // the oldest slot goes out as soon as its result is in.
    assign ret_valid = head_entry.busy && head_entry.done && !flush;

    assign ret = '{
        pc:   head_entry.pc,
        rd:   head_entry.rd,
        wen:  head_entry.wen,
        data: head_entry.data
    };

    assign retire_fire = ret_valid && ret_ready;

    always_comb begin
        rel       = '0;
        rel[head] = retire_fire; // frees the slot at the same edge the head moves.
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
        end else if (retire_fire) begin
            head <= head + slot_idx_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/commit_slot.sv ====
// One window entry, matched to writeback reports by PC.
// PCs in flight are assumed unique; if several ports report the same PC
// in one cycle, the lowest numbered port is taken.

`timescale 1ns/10ps
`default_nettype none

`include "commit_cfg.svh"

module commit_slot (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 alloc,
    input  commit_pkg::word_t    alloc_pc,
    input  commit_pkg::wb_arr_t  wb,
    input  logic                 rel,
    output commit_pkg::entry_t   entry
);
    import commit_pkg::*;

    logic      busy;
    logic      done;
    word_t     pc_q;
    reg_addr_t rd_q;
    logic      wen_q;
    word_t     data_q;

    logic      hit;
    reg_addr_t hit_rd;
    logic      hit_wen;
    word_t     hit_data;

    // all ports are compared in parallel, walked downwards so port 0 wins.
    always_comb begin
        hit      = 1'b0;
        hit_rd   = '0;
        hit_wen  = 1'b0;
        hit_data = '0;
        for (int p = `COMMIT_WB_PORTS - 1; p >= 0; p--) begin
            if (wb[p].valid && (wb[p].pc == pc_q)) begin
                hit      = 1'b1;
                hit_rd   = wb[p].rd;
                hit_wen  = wb[p].wen;
                hit_data = wb[p].data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush || rel) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (alloc) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (busy && hit) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            pc_q <= alloc_pc;
        end
        if (busy && !done && hit) begin // a free slot never captures.
            rd_q   <= hit_rd;
            wen_q  <= hit_wen;
            data_q <= hit_data;
        end
    end

    assign entry = '{busy: busy, done: done, pc: pc_q, rd: rd_q, wen: wen_q, data: data_q};

endmodule

`default_nettype wire

// ==== rtl/commit_alloc.sv ====
// Dispatch side of the window: tail pointer and occupancy count.
// disp_ready needs room for a full group of lanes, so a pair always fits.
// Lane 1 is expected only together with lane 0.

`timescale 1ns/10ps
`default_nettype none

`include "commit_cfg.svh"

module commit_alloc (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic [`COMMIT_LANES-1:0]   disp_valid,
    input  commit_pkg::lane_word_t     disp_pc,
    input  logic                       retire_fire,
    output logic                       disp_ready,
    output logic [`COMMIT_SLOTS-1:0]   alloc,
    output commit_pkg::slot_word_t     alloc_pc
);
    import commit_pkg::*;

    slot_idx_t tail;
    count_t    count;
    count_t    accepted;
    slot_idx_t lane_slot;

    // ready depends on the registered count only.
    assign disp_ready = (count <= count_t'(`COMMIT_SLOTS - `COMMIT_LANES));

    // lane l lands in the slot l places after the tail, wrapping around.
    always_comb begin
        alloc     = '0;
        alloc_pc  = '0;
        accepted  = '0;
        lane_slot = tail;
        for (int l = 0; l < `COMMIT_LANES; l++) begin
            lane_slot = tail + slot_idx_t'(l);
            if (disp_ready && disp_valid[l]) begin
                alloc[lane_slot]    = 1'b1;
                alloc_pc[lane_slot] = disp_pc[l];
                accepted            = accepted + count_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail + accepted[SLOT_AW-1:0]; // the low bits wrap with the ring.
            count <= count + accepted - count_t'(retire_fire);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/commit_pkg.sv ====
// Shared types of the commit window.
// Sizes come from commit_cfg.svh, so it must be on the include path.

`default_nettype none

`include "commit_cfg.svh"

package commit_pkg;

    localparam int SLOT_AW = $clog2(`COMMIT_SLOTS);

    typedef logic [SLOT_AW-1:0]         slot_idx_t;
    typedef logic [SLOT_AW:0]           count_t;    // holds 0 up to a full window.
    typedef logic [`COMMIT_XLEN-1:0]    word_t;
    typedef logic [`COMMIT_REG_AW-1:0]  reg_addr_t;

    typedef word_t [`COMMIT_LANES-1:0] lane_word_t;
    typedef word_t [`COMMIT_SLOTS-1:0] slot_word_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      wen;
        word_t     data;
    } wb_t;

    typedef wb_t [`COMMIT_WB_PORTS-1:0] wb_arr_t;

    typedef struct packed {
        logic      busy;  // slot holds a dispatched instruction.
        logic      done;  // its result has been captured.
        word_t     pc;
        reg_addr_t rd;
        logic      wen;
        word_t     data;
    } entry_t;

    typedef entry_t [`COMMIT_SLOTS-1:0] entry_arr_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        logic      wen;
        word_t     data;
    } retire_t;

endpackage

`default_nettype wire

// ==== rtl/commit_cfg.svh ====
// Sizes of the commit window.
// COMMIT_SLOTS must be a power of two and no smaller than COMMIT_LANES.
// COMMIT_XLEN sets both the PC width and the result data width.

`ifndef COMMIT_CFG_SVH
`define COMMIT_CFG_SVH

// number of in-flight instructions the window can track.
`define COMMIT_SLOTS 8

// instructions offered by decode per cycle, lane 0 is the older one.
`define COMMIT_LANES 2

// writeback ports reporting finished results per cycle.
`define COMMIT_WB_PORTS 3

`define COMMIT_XLEN 64   // pc and data width.
`define COMMIT_REG_AW 5  // register file address width.

`endif
